/* list.f */
+incdir+common
common/uart_pkg.sv
uart/uart_receiver.sv
uart/uart_transmitter.sv
verilog/uart_axil_regs.sv
verilog/uart_top.sv
dv/uart_checker.sv
dv/uart_tb.sv

/* Makefile */
# Verilator build and run of the uart peripheral testbench

TOOL       := verilator
FLAGS      := --binary -j 0
LINT_FLAGS := --lint-only --timing
TOP        := uart_tb
FLIST      := list.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# the log decides pass or fail
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/uart_tb.sv */
/*
  testbench top for the uart peripheral, random register and serial traffic
  inputs change on the falling edge, bready and rready stay high
  loopback routes uart_tx into uart_rx, otherwise uart_rx idles high
*/
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tb;
    import uart_pkg::*;

    localparam int WAIT_LIMIT = 4000;  // clocks or polls per wait

    logic       clk;
    logic       resetn;
    axil_req_t  axil_req;
    axil_rsp_t  axil_rsp;
    logic       uart_rx;
    logic       uart_tx;
    logic       loopback;
    axil_data_t exp_word;
    axil_data_t exp_mask;      // zero means the read is not compared
    axil_data_t rd_val;
    logic       end_of_test;
    logic       timed_out;
    string      timeout_what;
    int         seed;
    int         i;
    int         read_errs;
    int         frame_errs;
    uart_comp_t comp_val;
    uart_byte_t byte_a;
    uart_byte_t byte_b;
    logic [1:0] en_val;

    assign uart_rx = loopback ? uart_tx : 1'b1;

    uart_top dut
    (
        .clk      (clk),
        .resetn   (resetn),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .uart_rx  (uart_rx),
        .uart_tx  (uart_tx)
    );

    uart_checker chk
    (
        .clk         (clk),
        .resetn      (resetn),
        .axil_req    (axil_req),
        .axil_rsp    (axil_rsp),
        .uart_tx     (uart_tx),
        .exp_word    (exp_word),
        .exp_mask    (exp_mask),
        .end_of_test (end_of_test),
        .read_errs   (read_errs),
        .frame_errs  (frame_errs)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic flag_timeout(input string what);
        timeout_what = what;
        timed_out    = 1'b1;      // watchdog below ends the run
    endtask

    task automatic write_reg(input axil_addr_t addr, input axil_data_t data);
        int n;
        n = 0;
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        while (!axil_rsp.bvalid && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (!axil_rsp.bvalid)
            flag_timeout("write response");
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        @(negedge clk);           // response consumed
    endtask

    task automatic read_reg(input axil_addr_t addr, input axil_data_t exp,
                            input axil_data_t mask, output axil_data_t data);
        int n;
        n = 0;
        exp_word         = exp;
        exp_mask         = mask;
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        while (!axil_rsp.rvalid && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (!axil_rsp.rvalid)
            flag_timeout("read data");
        data             = axil_rsp.rdata;
        axil_req.arvalid = 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_rx_full();
        int n;
        n      = 0;
        rd_val = '0;
        while (!rd_val[0] && n < WAIT_LIMIT)
        begin
            read_reg(`UART_REG_STATUS, '0, '0, rd_val);
            n++;
        end
        if (!rd_val[0])
            flag_timeout("rx_full in STATUS");
    endtask

    // with tx_en off the DATA write sends nothing and completes once the line is idle
    task automatic wait_tx_idle(input logic rx_en);
        write_reg(`UART_REG_CTRL, {30'd0, 1'b0, rx_en});
        write_reg(`UART_REG_DATA, 32'h0000_00a5);
    endtask

    always @(posedge clk)
    begin
        if (timed_out)
        begin
            $display("timeout: no %s within %0d tries", timeout_what, WAIT_LIMIT);
            $display("errors: %0d read, %0d frame", read_errs, frame_errs);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial
    begin
        seed            = 31074;
        resetn          = 1'b0;
        axil_req        = '0;
        axil_req.bready = 1'b1;
        axil_req.rready = 1'b1;
        loopback        = 1'b0;
        exp_word        = '0;
        exp_mask        = '0;
        end_of_test     = 1'b0;
        timed_out       = 1'b0;
        timeout_what    = "";
        repeat (2) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);

        read_reg(`UART_REG_CTRL, 32'h0, '1, rd_val);
        read_reg(`UART_REG_BAUD, {16'd0, `UART_RESET_COMP}, '1, rd_val);
        read_reg(`UART_REG_STATUS, 32'h0, '1, rd_val);

        for (i = 0; i < 8; i++)
        begin
            comp_val = 16'(3 + ($random(seed) & 15));   // keeps mid-bit inside the bit
            en_val   = 2'($random(seed));
            write_reg(`UART_REG_BAUD, {16'd0, comp_val});
            write_reg(`UART_REG_CTRL, {30'd0, en_val});
            read_reg(`UART_REG_BAUD, {16'd0, comp_val}, '1, rd_val);
            read_reg(`UART_REG_CTRL, {30'd0, en_val}, '1, rd_val);
        end

        write_reg(`UART_REG_CTRL, 32'h2);   // tx only, frames decoded by the checker
        for (i = 0; i < 6; i++)
        begin
            byte_a = 8'($random(seed));
            write_reg(`UART_REG_DATA, {24'd0, byte_a});
            read_reg(`UART_REG_STATUS, 32'h4, '1, rd_val);
        end
        wait_tx_idle(1'b0);

        loopback = 1'b1;
        write_reg(`UART_REG_CTRL, 32'h3);
        for (i = 0; i < 6; i++)
        begin
            byte_a = 8'($random(seed));
            write_reg(`UART_REG_DATA, {24'd0, byte_a});
            wait_rx_full();
            read_reg(`UART_REG_DATA, {24'd0, byte_a}, '1, rd_val);
            read_reg(`UART_REG_STATUS, 32'h0, 32'h3, rd_val);   // tx may still be busy
        end

        // two frames without a DATA read in between
        byte_a = 8'($random(seed));
        byte_b = 8'($random(seed));
        write_reg(`UART_REG_DATA, {24'd0, byte_a});
        write_reg(`UART_REG_DATA, {24'd0, byte_b});
        wait_tx_idle(1'b1);
        read_reg(`UART_REG_STATUS, 32'h3, '1, rd_val);
        read_reg(`UART_REG_DATA, {24'd0, byte_b}, '1, rd_val);
        read_reg(`UART_REG_STATUS, 32'h0, '1, rd_val);

        write_reg(`UART_REG_CTRL, 32'h2);   // receiver off, line still looped
        byte_a = 8'($random(seed));
        write_reg(`UART_REG_DATA, {24'd0, byte_a});
        wait_tx_idle(1'b0);
        read_reg(`UART_REG_STATUS, 32'h0, '1, rd_val);

        end_of_test = 1'b1;
        @(negedge clk);
        @(negedge clk);
        $display("errors: %0d read, %0d frame", read_errs, frame_errs);
        if (read_errs == 0 && frame_errs == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* dv/uart_checker.sv */
/*
  watches the bus and uart_tx of the uart peripheral
  accepted writes feed a model of comp and tx_en and a queue of sent bytes
  reads are compared with the expected word under a mask, a zero mask skips it
  frame decode needs comp of at least 2 so that mid-bit lies inside each bit
*/
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_checker
(
    input  logic                 clk,
    input  logic                 resetn,
    input  uart_pkg::axil_req_t  axil_req,
    input  uart_pkg::axil_rsp_t  axil_rsp,
    input  logic                 uart_tx,
    input  uart_pkg::axil_data_t exp_word,
    input  uart_pkg::axil_data_t exp_mask,
    input  logic                 end_of_test,
    output int                   read_errs,
    output int                   frame_errs
);
    import uart_pkg::*;

    uart_byte_t tx_q[$];        // bytes that should show up on the line
    uart_byte_t exp_b;
    uart_comp_t comp_m;
    axil_addr_t rd_addr;
    logic       tx_en_m;
    logic       in_frame;
    logic       end_seen;
    logic [9:0] frame_bits;     // start bit ends up in bit 0
    int         t_cnt;
    int         period;
    int         bit_idx;

    always @(posedge clk)
    begin
        if (!resetn)
        begin
            comp_m     = `UART_RESET_COMP;
            tx_en_m    = 1'b0;
            in_frame   = 1'b0;
            end_seen   = 1'b0;
            read_errs  = 0;
            frame_errs = 0;
            tx_q.delete();
        end
        else
        begin
            if (axil_req.awvalid && axil_rsp.awready)
            begin
                case (axil_req.awaddr)
                    `UART_REG_CTRL: tx_en_m = axil_req.wdata[1];
                    `UART_REG_BAUD: comp_m = axil_req.wdata[15:0];
                    `UART_REG_DATA: if (tx_en_m) tx_q.push_back(axil_req.wdata[7:0]);
                    default: ;
                endcase
            end
            if (axil_req.arvalid && axil_rsp.arready)
                rd_addr = axil_req.araddr;
            if (axil_rsp.rvalid && axil_req.rready && exp_mask != '0)
            begin
                if (((axil_rsp.rdata ^ exp_word) & exp_mask) != '0 || axil_rsp.rresp != 2'b00)
                begin
                    read_errs++;
                    $display("FAILED at %0t: read of %h gave %08h, expected %08h mask %08h",
                             $time, rd_addr, axil_rsp.rdata, exp_word, exp_mask);
                end
            end
            if (axil_rsp.bvalid && axil_rsp.bresp != 2'b00)
            begin
                read_errs++;
                $display("FAILED at %0t: write response %b, expected OKAY", $time, axil_rsp.bresp);
            end
            // address and data are taken in the same cycle
            if (axil_rsp.awready != axil_rsp.wready)
            begin
                read_errs++;
                $display("FAILED at %0t: awready %b and wready %b differ",
                         $time, axil_rsp.awready, axil_rsp.wready);
            end

            // line decode, t_cnt 0 is the first low sample
            if (!in_frame && !uart_tx)
            begin
                in_frame = 1'b1;
                t_cnt    = 0;
                bit_idx  = 0;
                period   = int'(comp_m) + 1;
            end
            else if (in_frame)
                t_cnt++;
            if (in_frame && (t_cnt % period) == (period - 1) / 2)
            begin
                frame_bits = {uart_tx, frame_bits[9:1]};
                bit_idx++;
                if (bit_idx == 10)
                begin
                    in_frame = 1'b0;
                    if (tx_q.size() == 0)
                    begin
                        frame_errs++;
                        $display("FAILED at %0t: frame %03h on uart_tx with no byte written",
                                 $time, frame_bits);
                    end
                    else
                    begin
                        exp_b = tx_q.pop_front();
                        if (frame_bits != {1'b1, exp_b, 1'b0})
                        begin
                            frame_errs++;
                            $display("FAILED at %0t: frame %03h, expected %03h",
                                     $time, frame_bits, {1'b1, exp_b, 1'b0});
                        end
                    end
                end
            end

            if (end_of_test && !end_seen)
            begin
                end_seen = 1'b1;
                if (tx_q.size() != 0)
                begin
                    frame_errs += tx_q.size();
                    $display("FAILED at %0t: %0d written bytes never left uart_tx",
                             $time, tx_q.size());
                end
            end
        end
    end

endmodule

/* verilog/uart_top.sv */
/*
  uart peripheral top, axi4-lite register block over 8N1 receiver and transmitter
  uart_rx is used as is, synchronize it outside when it comes from another clock
*/
`timescale 1ns/1ps

module uart_top
(
    input  logic                clk,
    input  logic                resetn,
    input  uart_pkg::axil_req_t axil_req,
    output uart_pkg::axil_rsp_t axil_rsp,
    input  logic                uart_rx,
    output logic                uart_tx
);
    import uart_pkg::*;

    uart_ctrl_t ctrl;
    uart_byte_t tx_data;
    uart_byte_t rx_data;
    logic       tx_start;
    logic       tx_busy;
    logic       rx_valid;

    uart_axil_regs u_regs
    (
        .clk      (clk),
        .resetn   (resetn),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .ctrl     (ctrl),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    uart_receiver u_rx
    (
        .clk      (clk),
        .resetn   (resetn),
        .rec_en   (ctrl.rx_en),
        .comp     (ctrl.comp),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .uart_rx  (uart_rx)
    );

    uart_transmitter u_tx
    (
        .clk      (clk),
        .resetn   (resetn),
        .tx_en    (ctrl.tx_en),
        .comp     (ctrl.comp),      // both engines share one bit period
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy),
        .uart_tx  (uart_tx)
    );

endmodule

/* verilog/uart_axil_regs.sv */
/*
  axi4-lite slave with the uart register file, single outstanding read and write
  every write is taken as a full word, unmapped reads return zero with OKAY
  a DATA write is held off (no awready/wready) while the transmitter is busy
  reading DATA clears rx_full, reading STATUS clears overrun
*/
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_axil_regs
(
    input  logic                    clk,
    input  logic                    resetn,
    input  uart_pkg::axil_req_t     axil_req,
    output uart_pkg::axil_rsp_t     axil_rsp,
    output uart_pkg::uart_ctrl_t    ctrl,
    output uart_pkg::uart_byte_t    tx_data,
    output logic                    tx_start,
    input  logic                    tx_busy,
    input  uart_pkg::uart_byte_t    rx_data,
    input  logic                    rx_valid
);
    import uart_pkg::*;

    uart_ctrl_t     ctrl_q;
    uart_status_t   status;
    uart_byte_t     tx_byte;
    uart_byte_t     rx_byte;
    axil_data_t     rd_word;
    axil_data_t     rdata_q;
    logic           tx_start_q;
    logic           bvalid_q;
    logic           rvalid_q;
    logic           rx_full;
    logic           overrun;
    logic           wr_data_sel;
    logic           wr_fire;
    logic           rd_fire;
    logic           rd_data_clr;
    logic           rd_status_clr;

    assign wr_data_sel = (axil_req.awaddr == `UART_REG_DATA);

    // address and data are taken together, DATA waits for an idle transmitter
    assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid_q
                     && !(wr_data_sel && tx_busy);
    assign rd_fire = axil_req.arvalid && !rvalid_q;

    assign rd_data_clr   = rd_fire && (axil_req.araddr == `UART_REG_DATA);
    assign rd_status_clr = rd_fire && (axil_req.araddr == `UART_REG_STATUS);

    assign ctrl     = ctrl_q;
    assign tx_data  = tx_byte;
    assign tx_start = tx_start_q;

    always_comb
    begin
        axil_rsp.awready = wr_fire;
        axil_rsp.wready  = wr_fire;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = 2'b00;       // always OKAY
        axil_rsp.arready = rd_fire;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = 2'b00;
    end

    always_comb
    begin
        status.tx_busy = tx_busy;
        status.overrun = overrun;
        status.rx_full = rx_full;
    end

    always_comb
    begin
        case (axil_req.araddr)
            `UART_REG_DATA:   rd_word = {24'd0, rx_byte};
            `UART_REG_STATUS: rd_word = {29'd0, status};
            `UART_REG_CTRL:   rd_word = {30'd0, ctrl_q.tx_en, ctrl_q.rx_en};
            `UART_REG_BAUD:   rd_word = {16'd0, ctrl_q.comp};
            default:          rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            ctrl_q.rx_en <= 1'b0;
            ctrl_q.tx_en <= 1'b0;
            ctrl_q.comp  <= `UART_RESET_COMP;
            tx_start_q   <= 1'b0;
            bvalid_q     <= 1'b0;
            rvalid_q     <= 1'b0;
            rx_full      <= 1'b0;
            overrun      <= 1'b0;
        end
        else
        begin
            tx_start_q <= 1'b0;
            if (bvalid_q && axil_req.bready)
                bvalid_q <= 1'b0;
            if (wr_fire)
            begin
                bvalid_q <= 1'b1;
                case (axil_req.awaddr)
                    `UART_REG_CTRL:
                    begin
                        ctrl_q.rx_en <= axil_req.wdata[0];
                        ctrl_q.tx_en <= axil_req.wdata[1];
                    end
                    `UART_REG_BAUD: ctrl_q.comp <= axil_req.wdata[15:0];
                    `UART_REG_DATA: tx_start_q <= 1'b1;
                    default: ;                  // STATUS is read only
                endcase
            end

            if (rvalid_q && axil_req.rready)
                rvalid_q <= 1'b0;
            if (rd_fire)
                rvalid_q <= 1'b1;

            // a new byte wins over a clear in the same cycle
            if (rd_data_clr)
                rx_full <= 1'b0;
            if (rx_valid)
                rx_full <= 1'b1;
            if (rd_status_clr)
                overrun <= 1'b0;
            if (rx_valid && rx_full && !rd_data_clr)
                overrun <= 1'b1;                // old byte lost
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_fire && wr_data_sel)
            tx_byte <= axil_req.wdata[7:0];
        if (rd_fire)
            rdata_q <= rd_word;
        if (rx_valid)
            rx_byte <= rx_data;                 // newest byte replaces the old
    end

endmodule

/* uart/uart_transmitter.sv */
/*
  8N1 serial transmitter, lsb first
  the line goes low the cycle after tx_start, each bit lasts comp+1 clocks
  tx_start is ignored while busy or while tx_en is low
  clearing tx_en does not cut a frame short
*/
`timescale 1ns/1ps

module uart_transmitter
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                tx_en,
    input  uart_pkg::uart_comp_t comp,
    input  uart_pkg::uart_byte_t tx_data,
    input  logic                tx_start,   // one cycle pulse
    output logic                tx_busy,
    output logic                uart_tx
);
    import uart_pkg::*;

    typedef enum logic [0:0] { idle_s, send_s } tx_state_t;

    tx_state_t  state;
    logic [9:0] frame;          // stop, data, start from msb to lsb
    uart_comp_t bit_timer;
    logic [3:0] bit_cnt;
    logic       load;
    logic       bit_done;

    assign load     = (state == idle_s) && tx_start && tx_en;
    assign bit_done = (bit_timer >= comp);   // same period rule as the receiver

    assign tx_busy = (state == send_s);
    assign uart_tx = (state == send_s) ? frame[0] : 1'b1;   // idle line is high

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state     <= idle_s;
            bit_timer <= '0;
            bit_cnt   <= '0;
        end
        else if (load)
        begin
            state     <= send_s;
            bit_timer <= '0;
            bit_cnt   <= '0;
        end
        else if (state == send_s)
        begin
            bit_timer <= bit_timer + 1'b1;
            if (bit_done)
            begin
                bit_timer <= '0;
                bit_cnt   <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd9)
                    state <= idle_s;    // end of stop bit
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
            frame <= {1'b1, tx_data, 1'b0};
        else if (state == send_s && bit_done)
            frame <= {1'b1, frame[9:1]};
    end

endmodule

/* uart/uart_receiver.sv */
/*
  8N1 serial receiver, lsb first, no parity and no framing check
  a frame starts on the first low sample seen while idle
  each bit is sampled at count comp/2, rx_valid pulses once in the stop bit
*/
`timescale 1ns/1ps

module uart_receiver
(
    input  logic                clk,
    input  logic                resetn,
    input  logic                rec_en,     // clearing it aborts a frame at once
    input  uart_pkg::uart_comp_t comp,
    output uart_pkg::uart_byte_t rx_data,
    output logic                rx_valid,
    input  logic                uart_rx
);
    import uart_pkg::*;

    typedef enum logic [0:0] { wait_s, receive_s } rx_state_t;

    rx_state_t  state;
    rx_state_t  next_state;
    uart_byte_t shift_reg;      // start bit falls out after eight more shifts
    uart_comp_t bit_timer;
    logic [3:0] bit_cnt;

    assign rx_data = shift_reg;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            state <= wait_s;
        else if (!rec_en)
            state <= wait_s;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            wait_s:    if (!uart_rx) next_state = receive_s;      // start edge
            receive_s: if (bit_cnt == 4'd9) next_state = wait_s;  // stop bit reached
            default:   next_state = wait_s;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            bit_timer <= '0;
            bit_cnt   <= '0;
            rx_valid  <= 1'b0;
        end
        else if (!rec_en || state == wait_s)
        begin
            bit_timer <= '0;
            bit_cnt   <= '0;
            rx_valid  <= 1'b0;
        end
        else
        begin
            bit_timer <= bit_timer + 1'b1;
            if (bit_timer >= comp)
            begin
                bit_timer <= '0;
                bit_cnt   <= bit_cnt + 1'b1;
            end
            rx_valid <= (bit_cnt == 4'd9);
        end
    end

    // mid-bit sampling, start bit plus eight data bits
    always_ff @(posedge clk)
    begin
        if (rec_en && state == receive_s && bit_cnt < 4'd9 && bit_timer == (comp >> 1))
            shift_reg <= {uart_rx, shift_reg[7:1]};
    end

endmodule

/* common/uart_pkg.sv */
/*
  types shared by the uart register block, the serial engines and the testbench
  axi4-lite structs carry the handshake signals only, no strobes and no prot
*/
`include "uart_settings.svh"

package uart_pkg;

    typedef logic [7:0]                 uart_byte_t;
    typedef logic [15:0]                uart_comp_t;    // bit lasts comp+1 clocks
    typedef logic [31:0]                axil_data_t;
    typedef logic [`UART_ADDR_W-1:0]    axil_addr_t;

    // master side of the bus
    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    // slave side of the bus
    typedef struct packed {
        logic       awready;
        logic       wready;
        logic       bvalid;
        logic [1:0] bresp;
        logic       arready;
        logic       rvalid;
        axil_data_t rdata;
        logic [1:0] rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic       rx_en;
        logic       tx_en;
        uart_comp_t comp;
    } uart_ctrl_t;

    // declared msb first so that rx_full lands on bit 0
    typedef struct packed {
        logic tx_busy;
        logic overrun;
        logic rx_full;
    } uart_status_t;

endpackage

/* common/uart_settings.svh */
/*
  register map and reset values of the uart peripheral
  offsets are byte addresses on a 32-bit bus, low two bits always zero
  reset comp is kept small so that frames are short in simulation
*/
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// byte address width of the register space
`define UART_ADDR_W         4

// register offsets
`define UART_REG_DATA       4'h0    // rx byte on read, tx byte on write
`define UART_REG_STATUS     4'h4    // bit0 rx_full, bit1 overrun, bit2 tx_busy
`define UART_REG_CTRL       4'h8    // bit0 rx_en, bit1 tx_en
`define UART_REG_BAUD       4'hC    // bits 15:0 comp, one bit = comp+1 clocks

// bit period after reset
`define UART_RESET_COMP     16'd9

`endif
